//--- verilog.f
+incdir+dv
hw/opb_dram_pkg.sv
hw/opb_addr_decode.sv
hw/opb_slave_fsm.sv
hw/dram_read_seq.sv
hw/dram_state_counters.sv
hw/opb_dram_bridge.sv
dv/dram_model.sv
dv/tb_opb_dram_bridge.sv

//--- Makefile
# Verilator simulation of the OPB to DRAM read bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_opb_dram_bridge -f verilog.f
	./obj_dir/Vtb_opb_dram_bridge | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_pattern.svh
// word k of beat b returned for controller address a
function automatic logic [31:0] pattern_word(input logic [31:0] a, input int b, input int k);
   logic [23:0] low;
   low = 24'(a * 16 + b * 8 + k);
   return {8'ha5, low};                  // marker byte on top
endfunction

function automatic opb_dram_pkg::dram_data_t pattern_beat(input logic [31:0] a, input int b);
   opb_dram_pkg::dram_data_t beat;
   for (int k = 0; k < 9; k++) begin
      beat[k*32 +: 32] = pattern_word(a, b, k);
   end
   return beat;
endfunction

//--- dv/tb_opb_dram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_opb_dram_bridge;

   `include "tb_pattern.svh"

   localparam opb_dram_pkg::bus_word_t base_addr = 32'h1000_0000;
   localparam opb_dram_pkg::bus_word_t high_addr = 32'h1000_0FFF;
   localparam int n_rand_reads = 24;
   localparam int n_reads      = n_rand_reads + 2;   // plus aborted and follow-up read

   logic dram_clk = 1'b0;
   logic dram_rst = 1'b1;
   logic rnw = 1'b0;
   logic select = 1'b0;
   logic ctr_clear = 1'b0;
   logic stall = 1'b1;
   opb_dram_pkg::bus_word_t abus = '0;
   opb_dram_pkg::bus_word_t page_base = '0;

   opb_dram_pkg::dram_data_t  dram_rd_data;
   logic dram_rd_data_valid, dram_rd_data_end, dram_rdy;
   opb_dram_pkg::bus_word_t   rd_dbus;
   logic xfer_ack, tout_sup, dram_en;
   opb_dram_pkg::dram_addr_t  dram_addr;
   opb_dram_pkg::dram_cmd_t   dram_cmd;
   opb_dram_pkg::ctr_t ctr_idle, ctr_read_init, ctr_read_hold, ctr_read_wait, ctr_read_resp;

   opb_dram_pkg::bus_word_t  exp_word = '0;
   opb_dram_pkg::dram_addr_t exp_addr = '0;
   opb_dram_pkg::dram_addr_t held_addr = '0;
   logic quiet = 1'b0;          // no ack and no command allowed
   logic abort_win = 1'b0;      // no ack allowed
   logic en_q = 1'b0;
   logic tout_q = 1'b0;         // timeout suppress one cycle back
   int   value_errors = 0;
   int   other_errors = 0;
   int   cmd_count = 0;
   int   ack_count = 0;
   int   reads_done = 0;
   logic [31:0] rdy_rng = 32'hb02d;
   logic [31:0] addr_rng = 32'hb02d;

   opb_dram_bridge #(.base_addr(base_addr), .high_addr(high_addr)) opb_dram_bridge_i (
      .dram_clk(dram_clk), .dram_rst(dram_rst), .abus(abus), .rnw(rnw), .select(select),
      .page_base(page_base), .dram_rd_data(dram_rd_data),
      .dram_rd_data_valid(dram_rd_data_valid), .dram_rd_data_end(dram_rd_data_end),
      .dram_rdy(dram_rdy), .ctr_clear(ctr_clear), .rd_dbus(rd_dbus), .xfer_ack(xfer_ack),
      .tout_sup(tout_sup), .dram_addr(dram_addr), .dram_cmd(dram_cmd), .dram_en(dram_en),
      .ctr_idle(ctr_idle), .ctr_read_init(ctr_read_init), .ctr_read_hold(ctr_read_hold),
      .ctr_read_wait(ctr_read_wait), .ctr_read_resp(ctr_read_resp)
   );

   dram_model dram_model_i (
      .dram_clk(dram_clk), .dram_rst(dram_rst), .stall(stall), .dram_en(dram_en),
      .dram_addr(dram_addr), .dram_rdy(dram_rdy), .dram_rd_data(dram_rd_data),
      .dram_rd_data_valid(dram_rd_data_valid), .dram_rd_data_end(dram_rd_data_end)
   );

   always #4 dram_clk = ~dram_clk;   // 8 ns period

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // mapping rule applied to a bus address
   function automatic opb_dram_pkg::dram_addr_t ref_addr(input logic [31:0] a,
                                                         input logic [31:0] pb);
      logic [31:0] off;
      off = a - base_addr;
      return pb + (off >> 6) * 8;
   endfunction

   function automatic opb_dram_pkg::bus_word_t ref_word(input logic [31:0] a,
                                                        input logic [31:0] pb);
      logic [31:0] off;
      off = a - base_addr;
      return pattern_word(ref_addr(a, pb), int'(off[5]), int'(off[4:2]));
   endfunction

   task automatic check_word(input string name, input opb_dram_pkg::bus_word_t got,
                             input opb_dram_pkg::bus_word_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input opb_dram_pkg::dram_addr_t got,
                             input opb_dram_pkg::dram_addr_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_cmd(input string name, input opb_dram_pkg::dram_cmd_t got,
                            input opb_dram_pkg::dram_cmd_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("Fail %0t %s got %s expected %s", $time, name, got.name(), exp.name());
      end
   endtask

   task automatic check_count(input string name, input opb_dram_pkg::ctr_t got,
                              input opb_dram_pkg::ctr_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   // random back-pressure from the controller model
   always @(posedge dram_clk) begin
      rdy_rng = xorshift(rdy_rng);
      stall <= (rdy_rng[2:0] < 3'd5);
   end

   // compare process
   always @(posedge dram_clk) begin
      if (!dram_rst) begin
         if (xfer_ack) begin
            ack_count++;
            if (quiet || abort_win) begin
               other_errors++;
               $display("unexpected acknowledge at %0t", $time);
            end else begin
               check_word("rd_dbus", rd_dbus, exp_word);
               check_count("tout_sup before ack", 32'(tout_q), 1);
               check_count("tout_sup with ack", 32'(tout_sup), 0);
            end
         end else begin
            check_word("rd_dbus without ack", rd_dbus, '0);
         end
         if (quiet) begin
            check_count("tout_sup unclaimed", 32'(tout_sup), 0);
         end
         if (dram_en && !en_q) begin   // new command
            cmd_count++;
            held_addr = dram_addr;
            if (quiet) begin
               other_errors++;
               $display("unexpected DRAM command at %0t", $time);
            end
            check_cmd("dram_cmd", dram_cmd, opb_dram_pkg::cmd_read);
            check_addr("dram_addr", dram_addr, exp_addr);
         end else if (dram_en) begin
            check_addr("dram_addr held", dram_addr, held_addr);
         end
         en_q = dram_en;
         tout_q = tout_sup;
      end
   end

   task automatic start_read(input opb_dram_pkg::bus_word_t a);
      @(posedge dram_clk);
      abus     <= a;
      rnw      <= 1'b1;
      select   <= 1'b1;
      exp_word <= ref_word(a, page_base);
      exp_addr <= ref_addr(a, page_base);
   endtask

   task automatic bus_read(input opb_dram_pkg::bus_word_t a);
      start_read(a);
      @(posedge dram_clk);
      while (!xfer_ack) begin
         @(posedge dram_clk);
      end
      select <= 1'b0;
      reads_done++;
      @(posedge dram_clk);
   endtask

   task automatic bus_hold(input opb_dram_pkg::bus_word_t a, input logic is_read);
      @(posedge dram_clk);
      quiet  <= 1'b1;
      abus   <= a;
      rnw    <= is_read;
      select <= 1'b1;
      repeat (30) @(posedge dram_clk);
      select <= 1'b0;
      repeat (3) @(posedge dram_clk);
      quiet  <= 1'b0;
   endtask

   task automatic aborted_read(input opb_dram_pkg::bus_word_t a);
      abort_win <= 1'b1;
      start_read(a);
      @(posedge dram_clk);
      while (!tout_sup) begin
         @(posedge dram_clk);
      end
      repeat (2) @(posedge dram_clk);
      select <= 1'b0;                     // master gives up before the ack
      repeat (40) @(posedge dram_clk);
      check_count("tout_sup after abort", 32'(tout_sup), 0);
      abort_win <= 1'b0;
   endtask

   function automatic opb_dram_pkg::bus_word_t rand_in_window();
      addr_rng = xorshift(addr_rng);
      return base_addr + {20'h0, addr_rng[11:2], 2'b00};
   endfunction

   task automatic check_counter_sum(input int n);
      opb_dram_pkg::ctr_t s0;
      opb_dram_pkg::ctr_t s1;
      s0 = ctr_idle + ctr_read_init + ctr_read_hold + ctr_read_wait + ctr_read_resp;
      repeat (n) @(posedge dram_clk);
      s1 = ctr_idle + ctr_read_init + ctr_read_hold + ctr_read_wait + ctr_read_resp;
      check_count("counter sum growth", s1 - s0, n);
   endtask

   initial begin
      repeat (n_reads * 60 + 500) @(posedge dram_clk);
      $display("timeout: the run did not finish in time");
      $display("Done: errors found");
      $finish;
   end

   initial begin
      addr_rng  = xorshift(addr_rng);
      page_base = {addr_rng[31:12], 12'h000};
      repeat (3) @(posedge dram_clk);
      dram_rst  <= 1'b0;
      ctr_clear <= 1'b1;
      @(posedge dram_clk);
      ctr_clear <= 1'b0;
      @(posedge dram_clk);
      check_cmd("dram_cmd after reset", dram_cmd, opb_dram_pkg::cmd_write);
      check_addr("dram_addr after reset", dram_addr, '0);
      check_count("dram_en after reset", 32'(dram_en), 0);
      check_count("xfer_ack after reset", 32'(xfer_ack), 0);
      check_count("tout_sup after reset", 32'(tout_sup), 0);

      for (int i = 0; i < n_rand_reads; i++) begin
         if (i == 5) begin
            fork
               bus_read(rand_in_window());
               check_counter_sum(17);
            join
         end else begin
            bus_read(rand_in_window());
         end
      end

      bus_hold(high_addr + 32'h10, 1'b1);      // above the window
      bus_hold(base_addr - 32'h4, 1'b1);       // below it
      bus_hold(rand_in_window(), 1'b0);        // write inside

      aborted_read(rand_in_window());
      bus_read(rand_in_window());

      repeat (5) @(posedge dram_clk);
      check_count("ctr_read_init", ctr_read_init, cmd_count);
      check_count("ack count", ack_count, reads_done);

      $display("value errors %0d, other errors %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/dram_model.sv
`timescale 1ns/1ps
`default_nettype none

module dram_model #(
   parameter int latency = 6
) (
   input  wire                            dram_clk,
   input  wire                            dram_rst,
   input  wire                            stall,      // random back-pressure request
   input  wire                            dram_en,
   input  wire opb_dram_pkg::dram_addr_t  dram_addr,
   output logic                           dram_rdy,
   output opb_dram_pkg::dram_data_t       dram_rd_data,
   output logic                           dram_rd_data_valid,
   output logic                           dram_rd_data_end
);

   `include "tb_pattern.svh"

   logic                     busy;
   int                       cnt;
   opb_dram_pkg::dram_addr_t addr_q;   // address of the accepted command

   initial begin
      dram_rdy           = 1'b0;
      dram_rd_data       = '0;
      dram_rd_data_valid = 1'b0;
      dram_rd_data_end   = 1'b0;
      busy               = 1'b0;
      cnt                = 0;
      addr_q             = '0;
   end

   always @(posedge dram_clk) begin
      if (dram_rst) begin
         dram_rdy           <= 1'b0;
         dram_rd_data_valid <= 1'b0;
         dram_rd_data_end   <= 1'b0;
         busy               <= 1'b0;
      end else begin
         dram_rd_data_valid <= 1'b0;
         dram_rd_data_end   <= 1'b0;
         dram_rdy           <= !stall && !busy;
         if (dram_en && dram_rdy && !busy) begin   // command accepted
            busy   <= 1'b1;
            cnt    <= latency;
            addr_q <= dram_addr;
         end else if (busy) begin
            cnt <= cnt - 1;
            if (cnt == 1) begin
               dram_rd_data       <= pattern_beat(addr_q, 0);
               dram_rd_data_valid <= 1'b1;
            end else if (cnt == 0) begin
               dram_rd_data       <= pattern_beat(addr_q, 1);
               dram_rd_data_valid <= 1'b1;
               dram_rd_data_end   <= 1'b1;
               busy               <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/opb_dram_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module opb_dram_bridge #(
   parameter opb_dram_pkg::bus_word_t base_addr = 32'h1000_0000,
   parameter opb_dram_pkg::bus_word_t high_addr = 32'h1000_0FFF
) (
   input  wire                           dram_clk,
   input  wire                           dram_rst,
   input  wire opb_dram_pkg::bus_word_t  abus,
   input  wire                           rnw,
   input  wire                           select,
   input  wire opb_dram_pkg::bus_word_t  page_base,      // software page register
   input  wire opb_dram_pkg::dram_data_t dram_rd_data,
   input  wire                           dram_rd_data_valid,
   input  wire                           dram_rd_data_end,
   input  wire                           dram_rdy,
   input  wire                           ctr_clear,
   output wire opb_dram_pkg::bus_word_t  rd_dbus,
   output wire                           xfer_ack,
   output wire                           tout_sup,
   output wire opb_dram_pkg::dram_addr_t dram_addr,
   output wire opb_dram_pkg::dram_cmd_t  dram_cmd,
   output wire                           dram_en,
   output wire opb_dram_pkg::ctr_t       ctr_idle,
   output wire opb_dram_pkg::ctr_t       ctr_read_init,
   output wire opb_dram_pkg::ctr_t       ctr_read_hold,
   output wire opb_dram_pkg::ctr_t       ctr_read_wait,
   output wire opb_dram_pkg::ctr_t       ctr_read_resp
);

   wire                            in_window;
   wire                            capture;
   wire opb_dram_pkg::dram_addr_t  mapped_addr;
   wire                            beat_sel;
   wire opb_dram_pkg::word_idx_t   word_idx;
   wire                            read_en;       // level request, bus to DRAM side
   wire                            read_done;
   wire opb_dram_pkg::bus_word_t   read_word;
   wire opb_dram_pkg::dram_state_t seq_state;

   opb_addr_decode #(.base_addr(base_addr), .high_addr(high_addr)) addr_decode_i (
      .dram_clk(dram_clk), .dram_rst(dram_rst), .abus(abus), .capture(capture),
      .page_base(page_base), .in_window(in_window), .dram_addr(mapped_addr),
      .beat_sel(beat_sel), .word_idx(word_idx)
   );

   opb_slave_fsm slave_fsm_i (
      .dram_clk(dram_clk), .dram_rst(dram_rst), .select(select), .rnw(rnw),
      .in_window(in_window), .read_done(read_done), .read_word(read_word),
      .capture(capture), .read_en(read_en), .xfer_ack(xfer_ack),
      .tout_sup(tout_sup), .rd_dbus(rd_dbus)
   );

   dram_read_seq read_seq_i (
      .dram_clk(dram_clk), .dram_rst(dram_rst), .read_en(read_en),
      .mapped_addr(mapped_addr), .beat_sel(beat_sel), .word_idx(word_idx),
      .dram_rdy(dram_rdy), .dram_rd_data(dram_rd_data),
      .dram_rd_data_valid(dram_rd_data_valid), .dram_rd_data_end(dram_rd_data_end),
      .read_done(read_done), .read_word(read_word), .dram_addr(dram_addr),
      .dram_cmd(dram_cmd), .dram_en(dram_en), .state(seq_state)
   );

   dram_state_counters state_counters_i (
      .dram_clk(dram_clk), .ctr_clear(ctr_clear), .state(seq_state),
      .ctr_idle(ctr_idle), .ctr_read_init(ctr_read_init),
      .ctr_read_hold(ctr_read_hold), .ctr_read_wait(ctr_read_wait),
      .ctr_read_resp(ctr_read_resp)
   );

endmodule

`default_nettype wire

//--- hw/dram_state_counters.sv
`timescale 1ns/1ps
`default_nettype none

module dram_state_counters (
   input  wire                            dram_clk,
   input  wire                            ctr_clear,
   input  wire opb_dram_pkg::dram_state_t state,
   output opb_dram_pkg::ctr_t             ctr_idle,
   output opb_dram_pkg::ctr_t             ctr_read_init,
   output opb_dram_pkg::ctr_t             ctr_read_hold,
   output opb_dram_pkg::ctr_t             ctr_read_wait,
   output opb_dram_pkg::ctr_t             ctr_read_resp
);

   localparam int n_states = 5;

   opb_dram_pkg::ctr_t counts [n_states];   // indexed by state encoding

   // software clear only, counters survive a bridge reset
   always_ff @(posedge dram_clk) begin
      if (ctr_clear) begin
         for (int i = 0; i < n_states; i++) begin
            counts[i] <= '0;
         end
      end else begin
         for (int i = 0; i < n_states; i++) begin
            if (state == opb_dram_pkg::dram_state_t'(i)) begin
               counts[i] <= counts[i] + 1'b1;
            end
         end
      end
   end

   assign ctr_idle      = counts[0];
   assign ctr_read_init = counts[1];
   assign ctr_read_hold = counts[2];
   assign ctr_read_wait = counts[3];
   assign ctr_read_resp = counts[4];

endmodule

`default_nettype wire

//--- hw/dram_read_seq.sv
`timescale 1ns/1ps
`default_nettype none

module dram_read_seq (
   input  wire                           dram_clk,
   input  wire                           dram_rst,
   input  wire                           read_en,
   input  wire opb_dram_pkg::dram_addr_t mapped_addr,
   input  wire                           beat_sel,
   input  wire opb_dram_pkg::word_idx_t  word_idx,
   input  wire                           dram_rdy,
   input  wire opb_dram_pkg::dram_data_t dram_rd_data,
   input  wire                           dram_rd_data_valid,
   input  wire                           dram_rd_data_end,
   output logic                          read_done,
   output opb_dram_pkg::bus_word_t       read_word,
   output opb_dram_pkg::dram_addr_t      dram_addr,
   output opb_dram_pkg::dram_cmd_t       dram_cmd,
   output logic                          dram_en,
   output opb_dram_pkg::dram_state_t     state
);

   logic                     read_en_q;    // previous request level
   opb_dram_pkg::dram_data_t beat0;
   opb_dram_pkg::dram_data_t beat1;
   opb_dram_pkg::dram_data_t sel_beat;

   assign sel_beat = beat_sel ? beat1 : beat0;

   always_ff @(posedge dram_clk) begin
      if (dram_rst) begin
         state     <= opb_dram_pkg::ds_idle;
         read_en_q <= 1'b0;
         read_done <= 1'b0;
         dram_en   <= 1'b0;
         dram_cmd  <= opb_dram_pkg::cmd_write;
         dram_addr <= '0;
      end else begin
         read_en_q <= read_en;

         case (state)
            opb_dram_pkg::ds_idle: begin
               if (read_en && !read_en_q) begin   // rising edge of the request
                  state <= opb_dram_pkg::ds_read_init;
               end
            end

            opb_dram_pkg::ds_read_init: begin
               state     <= opb_dram_pkg::ds_read_hold;
               dram_en   <= 1'b1;
               dram_cmd  <= opb_dram_pkg::cmd_read;
               dram_addr <= mapped_addr;
            end

            opb_dram_pkg::ds_read_hold: begin
               // controller back-pressure, keep the command until taken
               if (dram_rdy) begin
                  state     <= opb_dram_pkg::ds_read_wait;
                  dram_en   <= 1'b0;
                  dram_cmd  <= opb_dram_pkg::cmd_write;
                  dram_addr <= '0;
               end
            end

            opb_dram_pkg::ds_read_wait: begin
               if (dram_rd_data_end) begin
                  state <= opb_dram_pkg::ds_read_resp;
               end
            end

            opb_dram_pkg::ds_read_resp: begin
               // done follows the request level, aborted reads just drain
               read_done <= read_en;
               if (!read_en) begin
                  state <= opb_dram_pkg::ds_idle;
               end
            end

            default: begin
               state <= opb_dram_pkg::ds_idle;
            end
         endcase
      end
   end

   // burst data path
   always_ff @(posedge dram_clk) begin
      if (state == opb_dram_pkg::ds_read_wait) begin
         if (dram_rd_data_end) begin
            beat1 <= dram_rd_data;         // closing beat
         end else if (dram_rd_data_valid) begin
            beat0 <= dram_rd_data;
         end
      end
      if (state == opb_dram_pkg::ds_read_resp && !read_done) begin
         read_word <= sel_beat[{word_idx, 5'd0} +: 32];   // word 8 never picked
      end
   end

   en_implies_read: assert property (
      @(posedge dram_clk) disable iff (dram_rst)
      dram_en |-> (dram_cmd == opb_dram_pkg::cmd_read)
   );

   // controller may stall, the address must not move meanwhile
   addr_stable_while_stalled: assert property (
      @(posedge dram_clk) disable iff (dram_rst)
      (dram_en && !dram_rdy) |=> $stable(dram_addr)
   );

endmodule

`default_nettype wire

//--- hw/opb_slave_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module opb_slave_fsm (
   input  wire                          dram_clk,
   input  wire                          dram_rst,
   input  wire                          select,
   input  wire                          rnw,
   input  wire                          in_window,
   input  wire                          read_done,
   input  wire opb_dram_pkg::bus_word_t read_word,
   output logic                         capture,
   output logic                         read_en,
   output logic                         xfer_ack,
   output logic                         tout_sup,
   output opb_dram_pkg::bus_word_t      rd_dbus
);

   opb_dram_pkg::opb_state_t state;

   // only reads inside the window are claimed, writes stay unanswered
   assign capture = (state == opb_dram_pkg::os_idle) && select && rnw && in_window;

   always_ff @(posedge dram_clk) begin
      if (dram_rst) begin
         state    <= opb_dram_pkg::os_idle;
         read_en  <= 1'b0;
         xfer_ack <= 1'b0;
         tout_sup <= 1'b0;
         rd_dbus  <= '0;
      end else begin
         xfer_ack <= 1'b0;                 // ack is a single pulse
         rd_dbus  <= '0;                   // bus data only valid with ack

         case (state)
            opb_dram_pkg::os_idle: begin
               if (capture) begin
                  state <= opb_dram_pkg::os_select;
               end
            end

            opb_dram_pkg::os_select: begin
               if (select) begin
                  state    <= opb_dram_pkg::os_read;
                  read_en  <= 1'b1;        // level request to the sequencer
                  tout_sup <= 1'b1;        // DRAM latency exceeds bus timeout
               end else begin
                  state <= opb_dram_pkg::os_idle;
               end
            end

            opb_dram_pkg::os_read: begin
               if (!select) begin
                  // master gave up, sequencer finishes the burst on its own
                  state    <= opb_dram_pkg::os_idle;
                  read_en  <= 1'b0;
                  tout_sup <= 1'b0;
               end else if (read_done) begin
                  state    <= opb_dram_pkg::os_read_x;
                  read_en  <= 1'b0;
                  tout_sup <= 1'b0;
                  xfer_ack <= 1'b1;
                  rd_dbus  <= read_word;
               end
            end

            opb_dram_pkg::os_read_x: begin
               state <= opb_dram_pkg::os_idle;   // let read_done fall first
            end

            default: begin
               state <= opb_dram_pkg::os_idle;
            end
         endcase
      end
   end

   // one ack per claimed read, never a stretched pulse
   ack_single_cycle: assert property (
      @(posedge dram_clk) disable iff (dram_rst)
      xfer_ack |=> !xfer_ack
   );

endmodule

`default_nettype wire

//--- hw/opb_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module opb_addr_decode #(
   parameter opb_dram_pkg::bus_word_t base_addr = 32'h0000_0000,
   parameter opb_dram_pkg::bus_word_t high_addr = 32'h0000_0FFF
) (
   input  wire                          dram_clk,
   input  wire                          dram_rst,
   input  wire opb_dram_pkg::bus_word_t abus,
   input  wire                          capture,
   input  wire opb_dram_pkg::bus_word_t page_base,
   output logic                         in_window,
   output opb_dram_pkg::dram_addr_t     dram_addr,
   output logic                         beat_sel,
   output opb_dram_pkg::word_idx_t      word_idx
);

   opb_dram_pkg::bus_word_t offset;

   assign offset    = abus - base_addr;   // byte offset into the window
   assign in_window = (abus >= base_addr) && (abus <= high_addr);

   // mapping is frozen at claim time so the sequencer sees a stable address
   always_ff @(posedge dram_clk) begin
      if (dram_rst) begin
         dram_addr <= '0;
         beat_sel  <= 1'b0;
         word_idx  <= '0;
      end else if (capture) begin
         dram_addr <= page_base
                      + (offset / opb_dram_pkg::burst_bytes) * opb_dram_pkg::burst_cols;
         beat_sel  <= offset[5];            // upper half of the burst
         word_idx  <= offset[4:2];          // word within the beat
      end
   end

   // the slave must never claim a cycle outside the window
   capture_in_window: assert property (
      @(posedge dram_clk) disable iff (dram_rst)
      capture |-> in_window
   );

endmodule

`default_nettype wire

//--- hw/opb_dram_pkg.sv
`default_nettype none

package opb_dram_pkg;

   // bus side word, address and data share one width
   typedef logic [31:0] bus_word_t;

   typedef logic [31:0]  dram_addr_t;   // native port command address
   typedef logic [287:0] dram_data_t;   // one beat, nine 32-bit words
   typedef logic [2:0]   word_idx_t;    // only words 0..7 are reachable
   typedef logic [31:0]  ctr_t;

   // controller command encoding
   typedef enum logic [2:0] {
      cmd_write = 3'd0,                 // never issued by the bridge
      cmd_read  = 3'd1
   } dram_cmd_t;

   typedef enum logic [2:0] {
      ds_idle      = 3'd0,
      ds_read_init = 3'd1,              // load command registers
      ds_read_hold = 3'd2,              // hold command until dram_rdy
      ds_read_wait = 3'd3,              // collect both beats
      ds_read_resp = 3'd4               // hand the word to the bus side
   } dram_state_t;

   typedef enum logic [2:0] {
      os_idle   = 3'd0,
      os_select = 3'd1,
      os_read   = 3'd2,
      os_read_x = 3'd3
   } opb_state_t;

   // one burst is two beats of eight used words
   localparam int unsigned burst_bytes = 64;

   // column step of the controller address per burst
   localparam int unsigned burst_cols = 8;

endpackage

`default_nettype wire
